//--- mvm_tile.f
+incdir+include
verilog/mvm_pkg.sv
verilog/mvm_tile_sequencer.sv
verilog/mvm_operand_store.sv
verilog/mvm_tile_accumulator.sv
verilog/mvm_tile.sv
bench/mvm_tile_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := mvm_tile_tb
FLIST     := mvm_tile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard include/*.svh verilog/*.sv bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mvm_tile_tb.sv
`timescale 1ns/1ps
`include "mvm_cfg.svh"

module mvm_tile_tb;

    localparam int R = `MVM_ROWS;
    localparam int C = `MVM_COLS;
    localparam int VW = `MVM_VEC_W;
    localparam int MW = `MVM_MAT_W;
    localparam int RW = `MVM_RES_W;
    localparam int FW = `MVM_FRAC_W;
    localparam int CLK_PERIOD = 8;
    localparam int RAND_PROBLEMS = 20;
    localparam int STALL_PROBLEMS = 5;
    localparam int MAX_STALL = 12;
    localparam int NUM_PROBLEMS = RAND_PROBLEMS + STALL_PROBLEMS + 2;
    localparam int WATCHDOG_CYCLES = NUM_PROBLEMS * (`MVM_TILES + 20) + MAX_STALL;
    localparam int RES_MAX = (1 << (RW - 1)) - 1;
    localparam int RES_MIN = -(1 << (RW - 1));

    logic                  clk;
    logic                  rst;
    logic [R*VW-1:0]       vector;
    logic                  vector_valid;
    logic                  vector_ready;
    logic [R*C*MW-1:0]     matrix;
    logic                  matrix_valid;
    logic                  matrix_ready;
    logic [C*RW-1:0]       result;
    logic                  result_valid;
    logic                  result_ready;
    logic                  error;

    int vec_cells [R];
    int mat_cells [R][C];    // row-major, [row][col]
    int exp_cells [C];
    int exp_error;
    int seed_dummy;

    mvm_tile dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic int result_cell(input int k);
        return int'($signed(result[k*RW +: RW]));
    endfunction

    // sum over rows at full precision, arithmetic shift, then clamp
    task automatic compute_expected();
        longint sum;
        longint scaled;
        exp_error = 0;
        for (int k = 0; k < C; k++) begin
            sum = 0;
            for (int r = 0; r < R; r++)
                sum += longint'(vec_cells[r]) * longint'(mat_cells[r][k]);
            scaled = sum >>> FW;
            if (scaled > RES_MAX) begin
                exp_cells[k] = RES_MAX;
                exp_error = 1;
            end else if (scaled < RES_MIN) begin
                exp_cells[k] = RES_MIN;
                exp_error = 1;
            end else
                exp_cells[k] = int'(scaled);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers, all called and returning on a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_accept();
        bit v_go;
        bit m_go;
        do begin
            v_go = vector_valid && vector_ready;
            m_go = matrix_valid && matrix_ready;
            @(negedge clk);
            if (v_go) vector_valid = 1'b0; // taken on the rising edge just passed
            if (m_go) matrix_valid = 1'b0;
        end while (vector_valid || matrix_valid);
    endtask

    // order 0 vector first, 1 matrix first, 2 same cycle
    task automatic offer_operands(input int order);
        for (int r = 0; r < R; r++) begin
            vector[r*VW +: VW] = VW'(vec_cells[r]);
            for (int k = 0; k < C; k++)
                matrix[(r*C + k)*MW +: MW] = MW'(mat_cells[r][k]);
        end
        vector_valid = (order != 1);
        matrix_valid = (order != 0);
        wait_accept();
        vector_valid = (order == 1);
        matrix_valid = (order == 0);
        if (order != 2)
            wait_accept();
    endtask

    task automatic collect_result(input int stall);
        int waited;
        int held_cells [C];
        int held_error;
        waited = 0;
        while (!result_valid) begin
            if (waited > `MVM_TILES + 20) begin
                $display("result_valid never rose after both operands were accepted");
                $display("FAIL: see errors above");
                $fatal(1, "no result");
            end
            @(negedge clk);
            waited++;
        end
        for (int k = 0; k < C; k++)
            held_cells[k] = result_cell(k);
        held_error = int'(error);
        repeat (stall) begin // result_ready held low
            @(negedge clk);
            check_value("result_valid", int'(result_valid), 1);
            check_value("error", int'(error), held_error);
            check_value("vector_ready", int'(vector_ready), 0);
            check_value("matrix_ready", int'(matrix_ready), 0);
            for (int k = 0; k < C; k++)
                check_value($sformatf("result[%0d]", k), result_cell(k), held_cells[k]);
        end
        for (int k = 0; k < C; k++)
            check_value($sformatf("result[%0d]", k), result_cell(k), exp_cells[k]);
        check_value("error", int'(error), exp_error);
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        check_value("result_valid", int'(result_valid), 0);
        check_value("vector_ready", int'(vector_ready), 1);
        check_value("matrix_ready", int'(matrix_ready), 1);
    endtask

    task automatic fill_random();
        for (int r = 0; r < R; r++) begin
            vec_cells[r] = int'($urandom_range(47)) - 24;
            for (int k = 0; k < C; k++)
                mat_cells[r][k] = int'($urandom_range(47)) - 24;
        end
        compute_expected();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_value("vector_ready", int'(vector_ready), 1);
        check_value("matrix_ready", int'(matrix_ready), 1);
        check_value("result_valid", int'(result_valid), 0);
        check_value("error", int'(error), 0);
    endtask

    task automatic test_identity();
        for (int r = 0; r < R; r++) begin
            vec_cells[r] = 7 - 3 * r;
            for (int k = 0; k < C; k++)
                mat_cells[r][k] = (r == k) ? (1 << FW) : 0; // 1.0 on the diagonal
        end
        for (int k = 0; k < C; k++)
            exp_cells[k] = vec_cells[k];
        exp_error = 0;
        offer_operands(2);
        collect_result(0);
    endtask

    task automatic test_random();
        for (int p = 0; p < RAND_PROBLEMS; p++) begin
            fill_random();
            offer_operands(int'($urandom_range(2)));
            collect_result(0);
        end
    endtask

    task automatic test_clamp();
        for (int r = 0; r < R; r++) begin
            vec_cells[r] = 100;
            mat_cells[r][0] = 100;  // large positive sum
            mat_cells[r][1] = -100; // large negative sum
            mat_cells[r][2] = 0;
            mat_cells[r][3] = 1;
        end
        exp_cells[0] = RES_MAX;
        exp_cells[1] = RES_MIN;
        exp_cells[2] = 0;
        exp_cells[3] = (R * 100) >>> FW;
        exp_error = 1;
        offer_operands(0);
        collect_result(0);
    endtask

    task automatic test_backpressure();
        for (int p = 0; p < STALL_PROBLEMS; p++) begin
            fill_random();
            offer_operands(int'($urandom_range(2)));
            collect_result(int'($urandom_range(MAX_STALL, 1)));
        end
    endtask

    initial begin
        seed_dummy = $urandom(21);
        rst = 1'b1;
        vector = '0;
        vector_valid = 1'b0;
        matrix = '0;
        matrix_valid = 1'b0;
        result_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_identity();
        test_random();
        test_clamp();
        test_backpressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog/mvm_tile.sv
`timescale 1ns/1ps
`include "mvm_cfg.svh"

module mvm_tile (
    input  logic                                       clk,
    input  logic                                       rst,
    // vector in
    input  logic [`MVM_ROWS*`MVM_VEC_W-1:0]            vector,
    input  logic                                       vector_valid,
    output logic                                       vector_ready,
    // matrix in, row-major
    input  logic [`MVM_ROWS*`MVM_COLS*`MVM_MAT_W-1:0]  matrix,
    input  logic                                       matrix_valid,
    output logic                                       matrix_ready,
    // result out
    output logic [`MVM_COLS*`MVM_RES_W-1:0]            result,
    output logic                                       result_valid,
    input  logic                                       result_ready,
    output logic                                       error
);

    mvm_pkg::tile_op_t                                      tile_op;
    logic [`MVM_ROW_IDX_W-1:0]                              tile_row;
    logic [`MVM_COL_IDX_W-1:0]                              tile_col;
    logic [`MVM_TILE_ROWS*`MVM_VEC_W-1:0]                   tile_vec;
    logic [`MVM_TILE_ROWS*`MVM_TILE_COLS*`MVM_MAT_W-1:0]    tile_mat;
    logic                                                   operands_full;
    logic                                                   release_pulse;

    mvm_tile_sequencer seq0 (
        .clk           (clk),
        .rst           (rst),
        .operands_full (operands_full),
        .release_pulse (release_pulse),
        .tile_op       (tile_op),
        .tile_row      (tile_row),
        .tile_col      (tile_col)
    );

    mvm_operand_store store0 (
        .clk           (clk),
        .rst           (rst),
        .vector        (vector),
        .vector_valid  (vector_valid),
        .vector_ready  (vector_ready),
        .matrix        (matrix),
        .matrix_valid  (matrix_valid),
        .matrix_ready  (matrix_ready),
        .release_pulse (release_pulse),
        .tile_row      (tile_row),
        .tile_col      (tile_col),
        .operands_full (operands_full),
        .tile_vec      (tile_vec),
        .tile_mat      (tile_mat)
    );

    mvm_tile_accumulator acc0 (
        .clk           (clk),
        .rst           (rst),
        .tile_op       (tile_op),
        .tile_col      (tile_col),
        .tile_vec      (tile_vec),
        .tile_mat      (tile_mat),
        .result        (result),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .error         (error),
        .release_pulse (release_pulse)
    );

endmodule

//--- verilog/mvm_tile_accumulator.sv
`timescale 1ns/1ps
`include "mvm_cfg.svh"

module mvm_tile_accumulator (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  mvm_pkg::tile_op_t                                    tile_op,
    input  logic [`MVM_COL_IDX_W-1:0]                            tile_col,
    input  logic [`MVM_TILE_ROWS*`MVM_VEC_W-1:0]                 tile_vec,
    input  logic [`MVM_TILE_ROWS*`MVM_TILE_COLS*`MVM_MAT_W-1:0]  tile_mat,
    // result out
    output logic [`MVM_COLS*`MVM_RES_W-1:0]                      result,
    output logic                                                 result_valid,
    input  logic                                                 result_ready,
    output logic                                                 error,
    output logic                                                 release_pulse
);

    localparam int VW    = `MVM_VEC_W;
    localparam int MW    = `MVM_MAT_W;
    localparam int RW    = `MVM_RES_W;
    localparam int ACC_W = `MVM_ACC_W;
    localparam int TC    = `MVM_TILE_COLS;

    // clamp bounds, sign extended to accumulator width
    localparam logic signed [ACC_W-1:0] RES_MAX = {{(ACC_W-RW+1){1'b0}}, {(RW-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] RES_MIN = {{(ACC_W-RW+1){1'b1}}, {(RW-1){1'b0}}};

    logic signed [ACC_W-1:0]    tile_sum [TC];
    logic signed [ACC_W-1:0]    acc      [`MVM_COLS];
    logic signed [ACC_W-1:0]    acc_next [`MVM_COLS];
    logic signed [ACC_W-1:0]    scaled   [`MVM_COLS];
    logic [`MVM_COLS*RW-1:0]    clamped;
    logic [`MVM_COLS-1:0]       clip;    // per cell saturation
    logic                       finish;  // op_last was added last cycle

    //////////////////////////////////////////////////////////////////////////
    // tile products, summed down each tile column
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int c = 0; c < TC; c++) begin
            tile_sum[c] = '0;
            for (int r = 0; r < `MVM_TILE_ROWS; r++)
                tile_sum[c] = tile_sum[c] + $signed(tile_vec[r*VW +: VW]) *
                              $signed(tile_mat[(r*TC + c)*MW +: MW]);
        end
    end

    // add tile columns into the accumulators from tile_col onward
    always_comb begin
        int off;
        for (int k = 0; k < `MVM_COLS; k++) begin
            off = k - int'(tile_col);
            acc_next[k] = (tile_op == mvm_pkg::op_first) ? '0 : acc[k];
            if (off >= 0 && off < TC)
                acc_next[k] = acc_next[k] + tile_sum[off];
        end
    end

    always_ff @(posedge clk) begin
        if (tile_op != mvm_pkg::op_none)
            acc <= acc_next;
    end

    always_ff @(posedge clk) begin
        if (rst)
            finish <= 1'b0;
        else
            finish <= (tile_op == mvm_pkg::op_last);
    end

    //////////////////////////////////////////////////////////////////////////
    // scale and clamp
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int k = 0; k < `MVM_COLS; k++) begin
            scaled[k] = acc[k] >>> `MVM_FRAC_W;
            clip[k]   = (scaled[k] > RES_MAX) || (scaled[k] < RES_MIN);
            if (scaled[k] > RES_MAX)
                clamped[k*RW +: RW] = RES_MAX[RW-1:0];
            else if (scaled[k] < RES_MIN)
                clamped[k*RW +: RW] = RES_MIN[RW-1:0];
            else
                clamped[k*RW +: RW] = scaled[k][RW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            error        <= 1'b0;
        end else if (finish) begin
            result_valid <= 1'b1;
            error        <= |clip;
        end else if (release_pulse) begin
            result_valid <= 1'b0;
            error        <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (finish)
            result <= clamped; // held until the handshake
    end

    // one-cycle pulse, result_valid drops on this edge
    assign release_pulse = result_valid && result_ready;

endmodule

//--- verilog/mvm_operand_store.sv
`timescale 1ns/1ps
`include "mvm_cfg.svh"

module mvm_operand_store (
    input  logic                                                   clk,
    input  logic                                                   rst,
    // vector in
    input  logic [`MVM_ROWS*`MVM_VEC_W-1:0]                        vector,
    input  logic                                                   vector_valid,
    output logic                                                   vector_ready,
    // matrix in, row-major
    input  logic [`MVM_ROWS*`MVM_COLS*`MVM_MAT_W-1:0]              matrix,
    input  logic                                                   matrix_valid,
    output logic                                                   matrix_ready,
    input  logic                                                   release_pulse,
    // tile window
    input  logic [`MVM_ROW_IDX_W-1:0]                              tile_row,
    input  logic [`MVM_COL_IDX_W-1:0]                              tile_col,
    output logic                                                   operands_full,
    output logic [`MVM_TILE_ROWS*`MVM_VEC_W-1:0]                   tile_vec,
    output logic [`MVM_TILE_ROWS*`MVM_TILE_COLS*`MVM_MAT_W-1:0]    tile_mat
);

    localparam int VW = `MVM_VEC_W;
    localparam int MW = `MVM_MAT_W;

    logic                                      vector_set;
    logic                                      matrix_set;
    logic [`MVM_ROWS*`MVM_VEC_W-1:0]           vector_buf;
    logic [`MVM_ROWS*`MVM_COLS*`MVM_MAT_W-1:0] matrix_buf;

    // each operand has its own flag, so arrival order does not matter
    always_ff @(posedge clk) begin
        if (rst || release_pulse) begin
            vector_set <= 1'b0;
            matrix_set <= 1'b0;
        end else begin
            if (vector_valid && vector_ready)
                vector_set <= 1'b1;
            if (matrix_valid && matrix_ready)
                matrix_set <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (vector_valid && vector_ready)
            vector_buf <= vector;
        if (matrix_valid && matrix_ready)
            matrix_buf <= matrix;
    end

    assign vector_ready  = !vector_set;
    assign matrix_ready  = !matrix_set;
    assign operands_full = vector_set && matrix_set;

    // window select, cells beyond the matrix read as zero
    always_comb begin
        int row_idx;
        int col_idx;
        for (int r = 0; r < `MVM_TILE_ROWS; r++) begin
            row_idx = int'(tile_row) + r;
            tile_vec[r*VW +: VW] = (row_idx < `MVM_ROWS) ? vector_buf[row_idx*VW +: VW] : '0;
            for (int c = 0; c < `MVM_TILE_COLS; c++) begin
                col_idx = int'(tile_col) + c;
                if (row_idx < `MVM_ROWS && col_idx < `MVM_COLS)
                    tile_mat[(r*`MVM_TILE_COLS + c)*MW +: MW] =
                        matrix_buf[(row_idx*`MVM_COLS + col_idx)*MW +: MW];
                else
                    tile_mat[(r*`MVM_TILE_COLS + c)*MW +: MW] = '0;
            end
        end
    end

endmodule

//--- verilog/mvm_tile_sequencer.sv
`timescale 1ns/1ps
`include "mvm_cfg.svh"

module mvm_tile_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       operands_full,
    input  logic                       release_pulse,
    output mvm_pkg::tile_op_t          tile_op,
    output logic [`MVM_ROW_IDX_W-1:0]  tile_row,
    output logic [`MVM_COL_IDX_W-1:0]  tile_col
);

    localparam int ROW_W = `MVM_ROW_IDX_W;
    localparam int COL_W = `MVM_COL_IDX_W;

    mvm_pkg::mvm_state_t state;

    logic [ROW_W-1:0] next_row;
    logic [COL_W-1:0] next_col;
    logic             row_wrap;     // current tile is the bottom one of its column strip
    logic             next_is_last;

    //////////////////////////////////////////////////////////////////////////
    // next tile coordinates, row tiles inner, column tiles outer
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        row_wrap = (int'(tile_row) + `MVM_TILE_ROWS) >= `MVM_ROWS;
        next_row = row_wrap ? '0 : ROW_W'(int'(tile_row) + `MVM_TILE_ROWS);
        next_col = row_wrap ? COL_W'(int'(tile_col) + `MVM_TILE_COLS) : tile_col;
        next_is_last = ((int'(next_row) + `MVM_TILE_ROWS) >= `MVM_ROWS) &&
                       ((int'(next_col) + `MVM_TILE_COLS) >= `MVM_COLS);
    end

    //////////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mvm_pkg::idle;
            tile_op  <= mvm_pkg::op_none;
            tile_row <= '0;
            tile_col <= '0;
        end else begin
            case (state)
                mvm_pkg::idle: begin
                    if (operands_full) begin
                        state   <= mvm_pkg::calc;
                        tile_op <= mvm_pkg::op_first; // tile (0,0)
                    end
                end
                mvm_pkg::calc: begin
                    if (tile_op == mvm_pkg::op_last) begin
                        state    <= mvm_pkg::hold;
                        tile_op  <= mvm_pkg::op_none;
                        tile_row <= '0;
                        tile_col <= '0;
                    end else begin
                        tile_op  <= next_is_last ? mvm_pkg::op_last : mvm_pkg::op_next;
                        tile_row <= next_row;
                        tile_col <= next_col;
                    end
                end
                mvm_pkg::hold: begin
                    if (release_pulse)
                        state <= mvm_pkg::idle; // result taken downstream
                end
                default: begin
                    state   <= mvm_pkg::idle;
                    tile_op <= mvm_pkg::op_none;
                end
            endcase
        end
    end

endmodule

//--- verilog/mvm_pkg.sv
package mvm_pkg;

    // tile sequencer states
    typedef enum logic [1:0] {
        idle = 2'd0, // waiting for both operands
        calc = 2'd1, // issuing tile opcodes
        hold = 2'd2  // result offered, waiting for release
    } mvm_state_t;

    // per-cycle opcode for the tile accumulator
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_first = 2'd1, // clear accumulators, then add
        op_next  = 2'd2, // add
        op_last  = 2'd3  // add, then finish
    } tile_op_t;

endpackage

//--- include/mvm_cfg.svh
`ifndef MVM_CFG_SVH
`define MVM_CFG_SVH

// problem size
`define MVM_COLS 4 // matrix columns, result cells
`define MVM_ROWS 5 // matrix rows, vector cells

// cell widths, signed fixed point
`define MVM_VEC_W 8
`define MVM_MAT_W 8
`define MVM_RES_W 8
`define MVM_FRAC_W 4

// tile shape, one tile per cycle
`define MVM_TILE_ROWS 3
`define MVM_TILE_COLS 3
`define MVM_TILES_R ((`MVM_ROWS + `MVM_TILE_ROWS - 1) / `MVM_TILE_ROWS)
`define MVM_TILES_C ((`MVM_COLS + `MVM_TILE_COLS - 1) / `MVM_TILE_COLS)
`define MVM_TILES (`MVM_TILES_R * `MVM_TILES_C)

// full precision sum of MVM_ROWS products
`define MVM_ACC_W (`MVM_VEC_W + `MVM_MAT_W + $clog2(`MVM_ROWS))
`define MVM_ROW_IDX_W ($clog2(`MVM_ROWS + 1))
`define MVM_COL_IDX_W ($clog2(`MVM_COLS + 1))

`endif
